// ==== flist.f ====
+incdir+src
src/modbus_pkg.sv
src/modbus_crc.sv
src/modbus_frame_timer.sv
src/holding_regs.sv
src/modbus_endpoint.sv
src/modbus_slave_top.sv
sim/modbus_properties.sv
sim/modbus_tb.sv

// ==== sim/modbus_properties.sv ====
// ============================
// handshake assertions on the endpoint
// bound into every modbus_endpoint
// fails counts assertion failures
// ============================
`timescale 1ns/1ns

module modbus_properties (
  input logic                 clk,
  input logic                 reset,
  input logic                 send,
  input logic                 txbusy,
  input modbus_pkg::mb_byte_t dout,
  input logic                 valid,
  input logic                 ack
);

  int unsigned fails = 0;  // failures so far

  // byte stays on offer until the transmitter takes it
  send_held: assert property (@(posedge clk) disable iff (reset)
    send && !txbusy |=> send)
    else begin
      $error("send dropped before txbusy was seen");
      fails++;
    end

  dout_stable: assert property (@(posedge clk) disable iff (reset)
    send |=> !send || $stable(dout))  // no change under send
    else begin
      $error("dout changed while send was high");
      fails++;
    end

  // bus request level held until the register file answers
  valid_held: assert property (@(posedge clk) disable iff (reset)
    valid && !ack |=> valid)
    else begin
      $error("valid dropped before ack");
      fails++;
    end

  reset_quiet: assert property (@(posedge clk) reset |=> !send && !valid)
    else begin
      $error("send or valid high right after reset");
      fails++;
    end

endmodule

bind modbus_endpoint modbus_properties u_props (
  .clk    (clk),
  .reset  (reset),
  .send   (send),
  .txbusy (txbusy),
  .dout   (dout),
  .valid  (valid),
  .ack    (ack)
);

// ==== sim/modbus_tb.sv ====
// ============================
// testbench for modbus_slave_top
// slave address 0x11 and frames from a table
// transmitter model busy 1 to 4 cycles
// expected replies from a register shadow
// stops at the first mismatch
// ============================
`timescale 1ns/1ns
`include "modbus_macros.svh"

module modbus_tb;

  localparam logic [6:0] SLAVE_ID   = 7'h11;
  localparam int         NROWS      = 22;
  localparam int         REPLY_WAIT = 2000;                 // cycles for a whole reply
  localparam int         IDLE_WAIT  = 100;
  localparam int         SILENCE    = 300 * `MB_TICK_DIV;   // longer than the timeout

  // one request frame
  typedef struct packed {
    logic [7:0]  slave;
    logic [7:0]  func;
    logic [15:0] w1;       // register address
    logic [15:0] w2;       // count or value
    logic        bad_crc;  // flip a crc bit
    logic        rx_err;   // rxerr pulse mid-frame
  } row_t;

  row_t rows [NROWS] = '{
    '{8'h11, 8'h06, 16'h0004, 16'hBEEF, 1'b0, 1'b0},  // write with echo
    '{8'h11, 8'h03, 16'h0004, 16'h0001, 1'b0, 1'b0},  // read it back
    '{8'h11, 8'h06, 16'h0006, 16'h1234, 1'b0, 1'b0},
    '{8'h11, 8'h06, 16'h0000, 16'hA5C3, 1'b0, 1'b0},
    '{8'h11, 8'h03, 16'h0000, 16'h0004, 1'b0, 1'b0},  // four words
    '{8'h11, 8'h03, 16'h0008, 16'h0000, 1'b0, 1'b0},  // count 0
    '{8'h11, 8'h03, 16'h0080, 16'h0002, 1'b0, 1'b0},  // unmapped
    '{8'h00, 8'h06, 16'h000A, 16'h5A5A, 1'b0, 1'b0},  // broadcast write
    '{8'h11, 8'h03, 16'h000A, 16'h0001, 1'b0, 1'b0},
    '{8'h00, 8'h03, 16'h0000, 16'h0002, 1'b0, 1'b0},  // broadcast read
    '{8'h22, 8'h03, 16'h0000, 16'h0001, 1'b0, 1'b0},  // other slave
    '{8'h11, 8'h03, 16'h0003, 16'h0001, 1'b0, 1'b0},  // odd address
    '{8'h11, 8'h03, 16'h0000, 16'h0080, 1'b0, 1'b0},  // count 128
    '{8'h11, 8'h06, 16'h0001, 16'h0001, 1'b0, 1'b0},  // odd write
    '{8'h11, 8'h05, 16'h0000, 16'hFF00, 1'b0, 1'b0},  // unknown function
    '{8'h11, 8'h03, 16'h0004, 16'h0001, 1'b1, 1'b0},  // bad crc
    '{8'h11, 8'h06, 16'h0004, 16'h0000, 1'b1, 1'b0},  // bad crc so no write
    '{8'h11, 8'h03, 16'h0004, 16'h0001, 1'b0, 1'b0},  // answered after timeout
    '{8'h11, 8'h06, 16'h000C, 16'h7777, 1'b0, 1'b1},  // rxerr
    '{8'h11, 8'h03, 16'h000C, 16'h0001, 1'b0, 1'b0},
    '{8'h11, 8'h06, 16'h003E, 16'hFFFF, 1'b0, 1'b0},  // top register
    '{8'h11, 8'h03, 16'h003C, 16'h0002, 1'b0, 1'b0}
  };

  logic                 clk;
  logic                 reset;
  modbus_pkg::mb_byte_t din;
  logic                 ready;
  logic                 rxerr;
  logic                 txbusy = 1'b0;
  modbus_pkg::mb_byte_t dout;
  logic                 send;

  integer               seed = 32'h104e_980c;
  int                   busy_left = 0;       // transmitter cycles left
  modbus_pkg::mb_byte_t reply_q [$];         // bytes the transmitter took
  modbus_pkg::mb_byte_t exp_q [$];
  modbus_pkg::mb_word_t shadow [`MB_REG_WORDS];
  logic                 expect_holdoff;

  modbus_slave_top UUT (
    .clk    (clk),
    .reset  (reset),
    .maddr  (SLAVE_ID),
    .din    (din),
    .ready  (ready),
    .rxerr  (rxerr),
    .txbusy (txbusy),
    .dout   (dout),
    .send   (send)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // transmitter model takes dout on send then stays busy a while
  always @(posedge clk) begin
    if (reset) begin
      txbusy <= 1'b0;
      busy_left = 0;
    end else if (busy_left > 0) begin
      busy_left = busy_left - 1;
      if (busy_left == 0)
        txbusy <= 1'b0;
    end else if (send && !txbusy) begin
      reply_q.push_back(dout);
      txbusy <= 1'b1;
      busy_left = 1 + ($unsigned($random(seed)) % 4);
    end
  end

  // bound handshake checker on the endpoint
  always @(posedge clk) begin
    if (UUT.u_endpoint.u_props.fails != 0)
      stop_with_failure("a handshake assertion on the endpoint failed");
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_byte(input string name, input modbus_pkg::mb_byte_t got,
                            input modbus_pkg::mb_byte_t exp);
    if (got !== exp)
      stop_with_failure($sformatf("FAILED %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_func(input modbus_pkg::mb_func_u got, input modbus_pkg::mb_func_u exp);
    if (got.raw !== exp.raw)
      stop_with_failure($sformatf("FAILED dout[1] func: got %h (exc %h code %h) expected %h",
                                  got.raw, got.field.is_exception, got.field.code, exp.raw));
  endtask

  // MODBUS crc stepped one message bit at a time from the lsb
  function automatic modbus_pkg::mb_word_t frame_crc(input modbus_pkg::mb_byte_t msg [$]);
    modbus_pkg::mb_word_t c;
    c = 16'hFFFF;
    foreach (msg[i]) begin
      for (int b = 0; b < 8; b++) begin
        if (c[0] ^ msg[i][b])
          c = (c >> 1) ^ 16'hA001;
        else
          c = c >> 1;
      end
    end
    return c;
  endfunction

  function automatic modbus_pkg::mb_word_t read_shadow(input modbus_pkg::mb_word_t a);
    if ((a >> 1) < `MB_REG_WORDS)
      return shadow[a >> 1];
    return 16'h0000;  // unmapped
  endfunction

  // expected reply bytes from the register shadow
  task automatic predict(input row_t r);
    logic                 unicast;
    logic                 bcast;
    modbus_pkg::mb_func_u ef;
    modbus_pkg::mb_word_t w;
    modbus_pkg::mb_word_t c;
    exp_q.delete();
    expect_holdoff = 1'b0;
    unicast        = (r.slave == {1'b0, SLAVE_ID});
    bcast          = (r.slave == 8'h00);
    ef.raw         = r.func;
    ef.field.is_exception = 1'b1;
    if (r.bad_crc || r.rx_err) begin
      expect_holdoff = 1'b1;  // silent until timeout
      return;
    end
    if ((r.func != `MB_FN_READ) && (r.func != `MB_FN_WRITE)) begin
      expect_holdoff = 1'b1;
      if (unicast) begin
        exp_q.push_back({1'b0, SLAVE_ID});
        exp_q.push_back(ef.raw);
        exp_q.push_back(`MB_EXC_FUNC);
      end
    end else if (!unicast && !bcast) begin
      return;
    end else if (r.w1[0] || ((r.func == `MB_FN_READ) && (r.w2 > 16'd127))) begin
      if (unicast) begin
        exp_q.push_back({1'b0, SLAVE_ID});
        exp_q.push_back(ef.raw);
        exp_q.push_back(`MB_EXC_DATA);
      end
    end else if (r.func == `MB_FN_WRITE) begin
      if ((r.w1 >> 1) < `MB_REG_WORDS)
        shadow[r.w1 >> 1] = r.w2;  // broadcast writes too
      if (unicast)
        exp_q = '{r.slave, r.func, r.w1[15:8], r.w1[7:0], r.w2[15:8], r.w2[7:0]};
    end else if (unicast) begin
      exp_q = '{r.slave, r.func, 8'(r.w2 * 2)};
      for (int i = 0; i < r.w2; i++) begin
        w = read_shadow(r.w1 + 16'(2 * i));
        exp_q.push_back(w[15:8]);  // high byte first
        exp_q.push_back(w[7:0]);
      end
    end
    if (exp_q.size() != 0) begin
      c = frame_crc(exp_q);
      exp_q.push_back(c[7:0]);
      exp_q.push_back(c[15:8]);
    end
  endtask

  task automatic drive_byte(input modbus_pkg::mb_byte_t b);
    @(posedge clk);
    din   <= b;
    ready <= 1'b1;
    @(posedge clk);
    ready <= 1'b0;
    repeat (3) @(posedge clk);  // gap between bytes
  endtask

  task automatic send_frame(input row_t r);
    modbus_pkg::mb_byte_t bytes [$];
    modbus_pkg::mb_word_t c;
    bytes = '{r.slave, r.func, r.w1[15:8], r.w1[7:0], r.w2[15:8], r.w2[7:0]};
    c     = frame_crc(bytes);
    if (r.bad_crc)
      c = c ^ 16'h0100;
    bytes.push_back(c[7:0]);  // low byte first on the wire
    bytes.push_back(c[15:8]);
    foreach (bytes[i]) begin
      if (r.rx_err && (i == 3)) begin
        @(posedge clk);
        rxerr <= 1'b1;
        @(posedge clk);
        rxerr <= 1'b0;
      end
      drive_byte(bytes[i]);
    end
  endtask

  task automatic wait_tx_idle();
    int n;
    n = 0;
    while (send || txbusy) begin
      @(posedge clk);
      n++;
      if (n > IDLE_WAIT)
        stop_with_failure("transmit handshake did not go idle");
    end
  endtask

  task automatic check_reply(input int row);
    int                   n;
    modbus_pkg::mb_func_u got_f;
    modbus_pkg::mb_func_u exp_f;
    n = 0;
    while (reply_q.size() < exp_q.size()) begin
      @(posedge clk);
      n++;
      if (n > REPLY_WAIT)
        stop_with_failure($sformatf("row %0d: reply missing, %0d of %0d bytes arrived",
                                    row, reply_q.size(), exp_q.size()));
    end
    foreach (exp_q[i]) begin
      if (i == 1) begin
        got_f.raw = reply_q[i];
        exp_f.raw = exp_q[i];
        check_func(got_f, exp_f);
      end else begin
        check_byte($sformatf("dout[%0d] row %0d", i, row), reply_q[i], exp_q[i]);
      end
    end
    repeat (exp_q.size()) void'(reply_q.pop_front());
  endtask

  // no send for longer than the timeout so hold-off ends in here
  task automatic expect_silence(input int row);
    wait_tx_idle();
    for (int n = 0; n < SILENCE; n++) begin
      @(posedge clk);
      if (send)
        stop_with_failure($sformatf("row %0d: reply sent where none was expected", row));
    end
  endtask

  initial begin
    reset = 1'b1;
    din   = 8'h00;
    ready = 1'b0;
    rxerr = 1'b0;
    foreach (shadow[i])
      shadow[i] = 16'h0000;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);
    foreach (rows[i]) begin
      wait_tx_idle();
      if (reply_q.size() != 0)
        stop_with_failure($sformatf("row %0d: %0d stray reply bytes before the request",
                                    i, reply_q.size()));
      predict(rows[i]);
      send_frame(rows[i]);
      if (exp_q.size() != 0)
        check_reply(i);
      if ((exp_q.size() == 0) || expect_holdoff)
        expect_silence(i);
    end
    wait_tx_idle();
    if ((reply_q.size() == 0) && (UUT.u_endpoint.u_props.fails == 0)) begin
      $display("All tests passed");
      $finish;
    end else begin
      stop_with_failure("stray reply bytes or handshake assertion failures at the end");
    end
  end

endmodule

// ==== src/holding_regs.sv ====
// ============================
// holding register file on the slave bus
// byte address, bit 0 ignored
// ack one cycle after valid rises
// unmapped reads give 0, writes dropped
// ============================
`timescale 1ns/1ns
`include "modbus_macros.svh"

module holding_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 valid,    // request level
  input  logic                 iswrite,
  input  modbus_pkg::mb_word_t addr,
  input  modbus_pkg::mb_word_t wdata,
  output modbus_pkg::mb_word_t rdata,
  output logic                 ack       // one cycle pulse
);

  localparam int IDX_W = $clog2(`MB_REG_WORDS);

  modbus_pkg::mb_word_t regs [`MB_REG_WORDS];

  logic             req;       // first cycle of a request
  logic             in_range;
  logic [IDX_W-1:0] idx;

  assign req      = valid && !ack;  // ack cycle closes the request
  assign in_range = (addr[15:1] < 15'(`MB_REG_WORDS));
  assign idx      = addr[IDX_W:1];  // word index

  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
      for (int i = 0; i < `MB_REG_WORDS; i++)
        regs[i] <= '0;
    end else begin
      ack <= req;
      if (req && iswrite && in_range)
        regs[idx] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (req)
      rdata <= in_range ? regs[idx] : 16'h0000;  // old value on writes
  end

endmodule

// ==== src/modbus_crc.sv ====
// ============================
// MODBUS CRC-16, one byte per strobe
// poly 0xA001 reflected, preset 0xFFFF
// restart wins over strobe
// crc valid the cycle after strobe
// ============================
`timescale 1ns/1ns

module modbus_crc (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 restart,  // back to preset
  input  logic                 strobe,   // fold in data this cycle
  input  modbus_pkg::mb_byte_t data,
  output modbus_pkg::mb_word_t crc
);

  // eight shift steps of the reflected CRC
  function automatic modbus_pkg::mb_word_t crc_byte(input modbus_pkg::mb_word_t c,
                                                    input modbus_pkg::mb_byte_t d);
    modbus_pkg::mb_word_t r;
    int i;
    r = c ^ {8'h00, d};  // byte enters at the lsb end
    for (i = 0; i < 8; i++) begin
      if (r[0])
        r = (r >> 1) ^ 16'hA001;
      else
        r = r >> 1;
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (reset || restart)
      crc <= 16'hFFFF;  // MODBUS preset
    else if (strobe)
      crc <= crc_byte(crc, data);
  end

endmodule

// ==== src/modbus_endpoint.sv ====
// ============================
// MODBUS RTU slave frame engine
// functions 0x03 and 0x06 only, rest get exception 0x01
// maddr must not be zero, address 0 is broadcast
// reply waits on the send/txbusy handshake, no time limit
// timeout applies while receiving and in hold-off only
// ============================
`timescale 1ns/1ns
`include "modbus_macros.svh"

module modbus_endpoint (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [6:0]           maddr,        // own slave address
  input  modbus_pkg::mb_byte_t din,          // received byte
  input  logic                 ready,        // din valid pulse
  input  logic                 rxerr,        // bad frame pulse
  input  logic                 txbusy,       // transmitter working
  input  logic                 expired,      // inactivity timeout
  input  modbus_pkg::mb_word_t rdata,
  input  logic                 ack,
  output modbus_pkg::mb_byte_t dout,         // byte to transmit
  output logic                 send,
  output logic                 frame_start,  // to frame timer
  output logic                 busy,
  output logic                 valid,        // slave bus request level
  output logic                 iswrite,
  output modbus_pkg::mb_word_t addr,
  output modbus_pkg::mb_word_t wdata
);

  typedef enum logic [4:0] {
    S_IDLE, S_RX_FUNC, S_RX_ADDR_H, S_RX_ADDR_L, S_RX_WORD_H, S_RX_WORD_L,
    S_RX_CRC_L, S_RX_CRC_H, S_WR_BUS, S_TX_PREP, S_TX_ADDR, S_TX_FUNC,
    S_TX_EXC_FUNC, S_TX_EXC_CODE, S_TX_RD_CNT, S_RD_BUS, S_TX_RD_HI,
    S_TX_RD_LO, S_TX_WR_AH, S_TX_WR_AL, S_TX_WR_DH, S_TX_WR_DL,
    S_TX_CRC_L, S_TX_CRC_H, S_HOLDOFF
  } state_t;

  state_t state;
  state_t tx_next;               // state after the byte on offer

  logic                 to_bcast;    // address byte was 0
  logic                 to_me;       // address byte was maddr
  logic                 is_write;    // function 0x06
  logic                 hold_after;  // hold-off once the reply is out
  logic [6:0]           dcnt;        // words left to read
  modbus_pkg::mb_func_u func_q;      // received function
  modbus_pkg::mb_func_u rx_func;
  modbus_pkg::mb_func_u exc_func;
  modbus_pkg::mb_word_t addr_q;      // register address, bumps per read word
  modbus_pkg::mb_word_t word_q;      // count or write value
  modbus_pkg::mb_word_t rd_word;     // last word from the bus
  modbus_pkg::mb_byte_t except_q;    // 0 means no exception
  modbus_pkg::mb_byte_t crc_lo;      // received crc low byte
  modbus_pkg::mb_byte_t tx_byte;
  modbus_pkg::mb_byte_t crc_data;
  modbus_pkg::mb_word_t crc;

  logic rx_state;     // idle or parsing a request
  logic listen;       // states where the master's timeout counts
  logic rx_strobe;    // request byte goes into the crc
  logic known_func;
  logic crc_ok;
  logic crc_restart;
  logic crc_strobe;
  logic tx_want;      // current state has a byte to offer
  logic tx_go;        // byte handed to the transmitter now

  // shared crc, request bytes first, then the reply
  modbus_crc u_crc (
    .clk     (clk),
    .reset   (reset),
    .restart (crc_restart),
    .strobe  (crc_strobe),
    .data    (crc_data),
    .crc     (crc)
  );

  assign rx_state = (state inside {S_IDLE, S_RX_FUNC, S_RX_ADDR_H, S_RX_ADDR_L,
                                   S_RX_WORD_H, S_RX_WORD_L, S_RX_CRC_L, S_RX_CRC_H});
  assign listen   = rx_state || (state == S_HOLDOFF);

  // crc bytes themselves are never folded in
  assign rx_strobe = ready && !rxerr &&
                     (state inside {S_IDLE, S_RX_FUNC, S_RX_ADDR_H, S_RX_ADDR_L,
                                    S_RX_WORD_H, S_RX_WORD_L});

  assign rx_func.raw = din;
  assign known_func  = (rx_func.raw == `MB_FN_READ) || (rx_func.raw == `MB_FN_WRITE);
  assign crc_ok      = ({din, crc_lo} == crc);  // high byte arrives last

  // exception reply reuses the function with the top bit set
  always_comb begin
    exc_func                    = func_q;
    exc_func.field.is_exception = 1'b1;
  end

  assign crc_restart = ((state == S_IDLE) && !ready) || (state == S_TX_PREP);
  assign crc_strobe  = rx_strobe ||
                       (tx_go && (state != S_TX_CRC_L) && (state != S_TX_CRC_H));
  assign crc_data    = rx_strobe ? din : tx_byte;

  // reply byte and successor for each transmit state
  always_comb begin
    tx_want = 1'b1;
    tx_byte = 8'h00;
    tx_next = S_IDLE;
    case (state)
      S_TX_ADDR: begin
        tx_byte = {1'b0, maddr};
        tx_next = (except_q != 8'h00) ? S_TX_EXC_FUNC : S_TX_FUNC;
      end
      S_TX_FUNC: begin
        tx_byte = func_q.raw;
        tx_next = is_write ? S_TX_WR_AH : S_TX_RD_CNT;
      end
      S_TX_EXC_FUNC: begin
        tx_byte = exc_func.raw;
        tx_next = S_TX_EXC_CODE;
      end
      S_TX_EXC_CODE: begin
        tx_byte = except_q;
        tx_next = S_TX_CRC_L;
      end
      S_TX_RD_CNT: begin
        tx_byte = {word_q[6:0], 1'b0};  // bytes = 2 * words
        tx_next = (word_q[6:0] == 7'd0) ? S_TX_CRC_L : S_RD_BUS;
      end
      S_TX_RD_HI: begin
        tx_byte = rd_word[15:8];  // high byte first
        tx_next = S_TX_RD_LO;
      end
      S_TX_RD_LO: begin
        tx_byte = rd_word[7:0];
        tx_next = (dcnt == 7'd0) ? S_TX_CRC_L : S_RD_BUS;
      end
      S_TX_WR_AH: begin
        tx_byte = addr_q[15:8];
        tx_next = S_TX_WR_AL;
      end
      S_TX_WR_AL: begin
        tx_byte = addr_q[7:0];
        tx_next = S_TX_WR_DH;
      end
      S_TX_WR_DH: begin
        tx_byte = word_q[15:8];
        tx_next = S_TX_WR_DL;
      end
      S_TX_WR_DL: begin
        tx_byte = word_q[7:0];
        tx_next = S_TX_CRC_L;
      end
      S_TX_CRC_L: begin
        tx_byte = crc[7:0];  // crc is low byte first on the wire
        tx_next = S_TX_CRC_H;
      end
      S_TX_CRC_H: begin
        tx_byte = crc[15:8];
        tx_next = hold_after ? S_HOLDOFF : S_IDLE;
      end
      default: tx_want = 1'b0;
    endcase
  end

  // next byte only once the previous one was taken and the line is free
  assign tx_go = tx_want && !send && !txbusy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= S_IDLE;
      send       <= 1'b0;
      except_q   <= 8'h00;
      hold_after <= 1'b0;
    end else begin
      if (send && txbusy)
        send <= 1'b0;  // byte accepted
      if (tx_go)
        send <= 1'b1;

      if (rx_state && rxerr) begin
        state <= S_HOLDOFF;  // silent until the timeout
      end else if (listen && expired) begin
        state <= S_IDLE;
      end else if (rx_state && ready) begin
        case (state)
          S_IDLE: begin
            except_q   <= 8'h00;
            hold_after <= 1'b0;
            state      <= S_RX_FUNC;
          end
          S_RX_FUNC: begin
            if (known_func) begin
              state <= S_RX_ADDR_H;
            end else begin
              // frame length unknown, answer now and then ignore the rest
              except_q   <= `MB_EXC_FUNC;
              hold_after <= 1'b1;
              state      <= to_me ? S_TX_PREP : S_HOLDOFF;
            end
          end
          S_RX_ADDR_H: state <= S_RX_ADDR_L;
          S_RX_ADDR_L: begin
            if (din[0])
              except_q <= `MB_EXC_DATA;  // odd register address
            state <= S_RX_WORD_H;
          end
          S_RX_WORD_H: begin
            if (!is_write && (din != 8'h00))
              except_q <= `MB_EXC_DATA;  // count over 127
            state <= S_RX_WORD_L;
          end
          S_RX_WORD_L: begin
            if (!is_write && din[7])
              except_q <= `MB_EXC_DATA;
            state <= S_RX_CRC_L;
          end
          S_RX_CRC_L: state <= S_RX_CRC_H;
          S_RX_CRC_H: begin
            if (!crc_ok)
              state <= S_HOLDOFF;
            else if (!to_bcast && !to_me)
              state <= S_IDLE;  // other slave
            else if ((except_q == 8'h00) && is_write)
              state <= S_WR_BUS;  // broadcast writes too
            else
              state <= to_me ? S_TX_PREP : S_IDLE;  // no broadcast replies
          end
          default: state <= S_IDLE;
        endcase
      end else begin
        case (state)
          S_WR_BUS:  if (ack) state <= to_me ? S_TX_PREP : S_IDLE;
          S_RD_BUS:  if (ack) state <= S_TX_RD_HI;
          S_TX_PREP: state <= S_TX_ADDR;  // crc back to preset here
          default:   if (tx_go) state <= tx_next;
        endcase
      end
    end
  end

  // request fields and reply data
  always_ff @(posedge clk) begin
    if (tx_go)
      dout <= tx_byte;
    if ((state == S_RD_BUS) && ack) begin
      rd_word <= rdata;
      addr_q  <= addr_q + 16'd2;  // next word
      dcnt    <= dcnt - 7'd1;
    end
    if (ready) begin
      case (state)
        S_IDLE: begin
          to_bcast <= (din == 8'h00);
          to_me    <= (din == {1'b0, maddr});
        end
        S_RX_FUNC: begin
          func_q   <= rx_func;
          is_write <= (rx_func.raw == `MB_FN_WRITE);
        end
        S_RX_ADDR_H: addr_q[15:8] <= din;
        S_RX_ADDR_L: addr_q[7:0]  <= din;
        S_RX_WORD_H: word_q[15:8] <= din;
        S_RX_WORD_L: begin
          word_q[7:0] <= din;
          dcnt        <= din[6:0];  // read count, unused for writes
        end
        S_RX_CRC_L: crc_lo <= din;
        default: ;
      endcase
    end
  end

  assign frame_start = (state == S_IDLE) && (ready || rxerr);  // any byte opens a frame
  assign busy        = (state != S_IDLE);
  assign valid       = (state == S_RD_BUS) || (state == S_WR_BUS);  // drops after ack
  assign iswrite     = (state == S_WR_BUS);
  assign addr        = addr_q;
  assign wdata       = word_q;

endmodule

// ==== src/modbus_frame_timer.sv ====
// ============================
// inactivity timer for the endpoint
// tick every MB_TICK_DIV clk cycles
// expiry after 2**MB_TMO_BITS-1 ticks
// of busy with no new frame_start
// expired stays high while busy at zero
// ============================
`timescale 1ns/1ns
`include "modbus_macros.svh"

module modbus_frame_timer (
  input  logic clk,
  input  logic reset,
  input  logic frame_start,  // reload pulse, first byte of a frame
  input  logic busy,         // endpoint not idle
  output logic expired
);

  localparam int DIV_W = $clog2(`MB_TICK_DIV);

  logic [DIV_W-1:0]        pre;   // free running prescaler
  logic                    tick;
  logic [`MB_TMO_BITS-1:0] cnt;   // inactivity countdown

  assign tick = (pre == DIV_W'(`MB_TICK_DIV - 1));

  always_ff @(posedge clk) begin
    if (reset)
      pre <= '0;
    else if (tick)
      pre <= '0;
    else
      pre <= pre + 1'b1;
  end

  // loaded to all ones, counts down only while busy
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '1;
    end else if (frame_start) begin
      cnt <= '1;  // new frame restarts the window
    end else if (busy && tick && (cnt != '0)) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign expired = busy && (cnt == '0);  // level, idle never expires

endmodule

// ==== src/modbus_macros.svh ====
// ============================
// constants for the MODBUS RTU slave
// MB_TICK_DIV must be 2 or more
// MB_REG_WORDS must be a power of two
// codes are 8-bit sized literals
// ============================
`ifndef MODBUS_MACROS_SVH
`define MODBUS_MACROS_SVH

// inactivity countdown width, timeout is 2**bits-1 ticks
`define MB_TMO_BITS 8

// clk cycles per timeout tick
`define MB_TICK_DIV 4

// holding registers, at even byte addresses from 0
`define MB_REG_WORDS 32

`define MB_FN_READ  8'h03  // read holding registers
`define MB_FN_WRITE 8'h06  // write single register

`define MB_EXC_FUNC 8'h01  // illegal function
`define MB_EXC_DATA 8'h03  // illegal data value

`endif

// ==== src/modbus_pkg.sv ====
// ============================
// shared MODBUS types
// the function byte is read two ways,
// as a raw code or split into the
// exception flag and the 7-bit code
// ============================
package modbus_pkg;

  // one serial byte as seen on din and dout
  typedef logic [7:0] mb_byte_t;

  // register value or register address
  typedef logic [15:0] mb_word_t;

  // function byte split into its fields
  // replies with the top bit set are exceptions
  typedef struct packed {
    logic       is_exception;  // set in exception replies
    logic [6:0] code;          // function number
  } mb_func_s;

  // same 8 bits, either whole or split
  typedef union packed {
    mb_byte_t raw;    // byte as received or sent
    mb_func_s field;  // flag plus code
  } mb_func_u;

endpackage

// ==== src/modbus_slave_top.sv ====
// ============================
// MODBUS RTU slave, byte level
// byte receiver and transmitter are external
// maddr must be 1..127
// ============================
`timescale 1ns/1ns

module modbus_slave_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [6:0]           maddr,
  input  modbus_pkg::mb_byte_t din,
  input  logic                 ready,
  input  logic                 rxerr,
  input  logic                 txbusy,
  output modbus_pkg::mb_byte_t dout,
  output logic                 send
);

  logic                 frame_start;
  logic                 busy;
  logic                 expired;
  logic                 valid;
  logic                 iswrite;
  logic                 ack;
  modbus_pkg::mb_word_t addr;
  modbus_pkg::mb_word_t wdata;
  modbus_pkg::mb_word_t rdata;

  modbus_endpoint u_endpoint (
    .clk         (clk),
    .reset       (reset),
    .maddr       (maddr),
    .din         (din),
    .ready       (ready),
    .rxerr       (rxerr),
    .txbusy      (txbusy),
    .expired     (expired),
    .rdata       (rdata),
    .ack         (ack),
    .dout        (dout),
    .send        (send),
    .frame_start (frame_start),
    .busy        (busy),
    .valid       (valid),
    .iswrite     (iswrite),
    .addr        (addr),
    .wdata       (wdata)
  );

  // inactivity timeout
  modbus_frame_timer u_timer (
    .clk         (clk),
    .reset       (reset),
    .frame_start (frame_start),
    .busy        (busy),
    .expired     (expired)
  );

  holding_regs u_regs (
    .clk     (clk),
    .reset   (reset),
    .valid   (valid),
    .iswrite (iswrite),
    .addr    (addr),
    .wdata   (wdata),
    .rdata   (rdata),
    .ack     (ack)
  );

endmodule
